//--- lc3b_pipe_pkg.sv
package lc3b_pipe_pkg;

    localparam int WORD_W    = 16;
    localparam int REG_COUNT = 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [2:0]        reg_idx_t;
    typedef logic [2:0]        nzp_t;

    localparam word_t RESET_PC  = 16'h0000;
    // br with an empty nzp field never redirects
    localparam word_t NOP_INSTR = 16'h0000;

    typedef enum logic [3:0] {
        OP_BR  = 4'b0000,
        OP_ADD = 4'b0001,
        OP_AND = 4'b0101,
        OP_LDR = 4'b0110,
        OP_STR = 4'b0111,
        OP_NOT = 4'b1001,
        OP_JMP = 4'b1100,
        OP_LEA = 4'b1110
    } opcode_e;

    typedef enum logic [1:0] {ALU_ADD, ALU_AND, ALU_NOT, ALU_PASS_B} alu_op_e;
    typedef enum logic [1:0] {B_REG, B_IMM5, B_OFF6} alu_b_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC_OFF} wb_sel_e;
    typedef enum logic [1:0] {FWD_RF, FWD_MEM, FWD_WB} fwd_sel_e;

    typedef struct packed {
        alu_op_e    alu_op;
        alu_b_sel_e alu_b_sel;
        wb_sel_e    wb_sel;
        logic       load_regfile;
        logic       load_cc;
        logic       mem_read;
        logic       mem_write;
        logic       is_branch;
        logic       is_jump;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        reg_idx_t dest;
        reg_idx_t src1;
        reg_idx_t src2;
        word_t    src1_data;
        word_t    src2_data;
        // pc of the next instruction
        word_t    pc;
        // raw instruction bits 10:0
        word_t    imm;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        reg_idx_t dest;
        word_t    alu;
        word_t    pc_plus_off;
        word_t    wdata;
        nzp_t     nzp;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t    ctrl;
        reg_idx_t dest;
        word_t    alu;
        word_t    rdata;
        word_t    pc_plus_off;
        nzp_t     nzp;
    } mem_wb_t;

endpackage

//--- lc3b_pipe_fetch.sv
`timescale 1ns/10ps

module lc3b_pipe_fetch (
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  lc3b_pipe_pkg::word_t i_instr,
    input  logic                 i_flush,
    input  lc3b_pipe_pkg::word_t i_target,
    output lc3b_pipe_pkg::word_t o_pc,
    output lc3b_pipe_pkg::word_t o_ifid_instr,
    output lc3b_pipe_pkg::word_t o_ifid_pc
);

    lc3b_pipe_pkg::word_t pc_q;
    lc3b_pipe_pkg::word_t pc_plus2;
    lc3b_pipe_pkg::word_t pc_next;

    assign pc_plus2 = pc_q + 16'd2;
    // a redirect from wb wins over sequential fetch
    assign pc_next  = i_flush ? i_target : pc_plus2;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q <= lc3b_pipe_pkg::RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // if/id register
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ifid_instr <= lc3b_pipe_pkg::NOP_INSTR;
            o_ifid_pc    <= '0;
        end else if (i_flush) begin
            o_ifid_instr <= lc3b_pipe_pkg::NOP_INSTR;
            o_ifid_pc    <= '0;
        end else begin
            o_ifid_instr <= i_instr;
            o_ifid_pc    <= pc_plus2;
        end
    end

    assign o_pc = pc_q;

endmodule

//--- lc3b_pipe_decode.sv
`timescale 1ns/10ps

module lc3b_pipe_decode (
    input  lc3b_pipe_pkg::word_t    i_instr,
    output lc3b_pipe_pkg::ctrl_t    o_ctrl,
    output lc3b_pipe_pkg::reg_idx_t o_dest,
    output lc3b_pipe_pkg::reg_idx_t o_src1,
    output lc3b_pipe_pkg::reg_idx_t o_src2,
    output lc3b_pipe_pkg::word_t    o_imm
);

    lc3b_pipe_pkg::opcode_e opcode;

    assign opcode = lc3b_pipe_pkg::opcode_e'(i_instr[15:12]);
    // for br the dest field holds nzp
    assign o_dest = i_instr[11:9];
    assign o_src1 = i_instr[8:6];
    assign o_imm  = {5'b0, i_instr[10:0]};

    always_comb begin
        o_ctrl = '0;
        o_src2 = i_instr[2:0];
        case (opcode)
            lc3b_pipe_pkg::OP_ADD,
            lc3b_pipe_pkg::OP_AND: begin
                o_ctrl.alu_op       = (opcode == lc3b_pipe_pkg::OP_ADD) ?
                                      lc3b_pipe_pkg::ALU_ADD : lc3b_pipe_pkg::ALU_AND;
                o_ctrl.alu_b_sel    = i_instr[5] ? lc3b_pipe_pkg::B_IMM5 : lc3b_pipe_pkg::B_REG;
                o_ctrl.load_regfile = 1'b1;
                o_ctrl.load_cc      = 1'b1;
            end
            lc3b_pipe_pkg::OP_NOT: begin
                o_ctrl.alu_op       = lc3b_pipe_pkg::ALU_NOT;
                o_ctrl.load_regfile = 1'b1;
                o_ctrl.load_cc      = 1'b1;
            end
            lc3b_pipe_pkg::OP_LEA: begin
                o_ctrl.wb_sel       = lc3b_pipe_pkg::WB_PC_OFF;
                o_ctrl.load_regfile = 1'b1;
                o_ctrl.load_cc      = 1'b1;
            end
            lc3b_pipe_pkg::OP_LDR: begin
                o_ctrl.alu_b_sel    = lc3b_pipe_pkg::B_OFF6;
                o_ctrl.wb_sel       = lc3b_pipe_pkg::WB_MEM;
                o_ctrl.mem_read     = 1'b1;
                o_ctrl.load_regfile = 1'b1;
                o_ctrl.load_cc      = 1'b1;
            end
            lc3b_pipe_pkg::OP_STR: begin
                o_ctrl.alu_b_sel = lc3b_pipe_pkg::B_OFF6;
                o_ctrl.mem_write = 1'b1;
                // store data rides on the b operand
                o_src2           = i_instr[11:9];
            end
            lc3b_pipe_pkg::OP_BR: begin
                o_ctrl.is_branch = 1'b1;
            end
            lc3b_pipe_pkg::OP_JMP: begin
                // base register passes through the alu as operand b
                o_ctrl.alu_op  = lc3b_pipe_pkg::ALU_PASS_B;
                o_ctrl.is_jump = 1'b1;
                o_src2         = i_instr[8:6];
            end
            default: o_ctrl = '0;
        endcase
    end

endmodule

//--- lc3b_pipe_regfile.sv
`timescale 1ns/10ps

module lc3b_pipe_regfile (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic                    i_we,
    input  lc3b_pipe_pkg::reg_idx_t i_waddr,
    input  lc3b_pipe_pkg::word_t    i_wdata,
    input  lc3b_pipe_pkg::reg_idx_t i_raddr_a,
    input  lc3b_pipe_pkg::reg_idx_t i_raddr_b,
    output lc3b_pipe_pkg::word_t    o_rdata_a,
    output lc3b_pipe_pkg::word_t    o_rdata_b
);

    lc3b_pipe_pkg::word_t regs [lc3b_pipe_pkg::REG_COUNT];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < lc3b_pipe_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // write-through so id sees the value retiring in wb
    assign o_rdata_a = (i_we && i_waddr == i_raddr_a) ? i_wdata : regs[i_raddr_a];
    assign o_rdata_b = (i_we && i_waddr == i_raddr_b) ? i_wdata : regs[i_raddr_b];

endmodule

//--- lc3b_pipe_forward.sv
`timescale 1ns/10ps

module lc3b_pipe_forward (
    input  lc3b_pipe_pkg::reg_idx_t i_src1,
    input  lc3b_pipe_pkg::reg_idx_t i_src2,
    input  lc3b_pipe_pkg::reg_idx_t i_dest_mem,
    input  lc3b_pipe_pkg::reg_idx_t i_dest_wb,
    input  logic                    i_we_mem,
    input  logic                    i_we_wb,
    output lc3b_pipe_pkg::fwd_sel_e o_sel_a,
    output lc3b_pipe_pkg::fwd_sel_e o_sel_b
);

    // mem holds the younger producer, so it is checked first
    always_comb begin
        if (i_we_mem && i_dest_mem == i_src1) begin
            o_sel_a = lc3b_pipe_pkg::FWD_MEM;
        end else if (i_we_wb && i_dest_wb == i_src1) begin
            o_sel_a = lc3b_pipe_pkg::FWD_WB;
        end else begin
            o_sel_a = lc3b_pipe_pkg::FWD_RF;
        end

        if (i_we_mem && i_dest_mem == i_src2) begin
            o_sel_b = lc3b_pipe_pkg::FWD_MEM;
        end else if (i_we_wb && i_dest_wb == i_src2) begin
            o_sel_b = lc3b_pipe_pkg::FWD_WB;
        end else begin
            o_sel_b = lc3b_pipe_pkg::FWD_RF;
        end
    end

endmodule

//--- lc3b_pipe_execute.sv
`timescale 1ns/10ps

module lc3b_pipe_execute (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic                    i_flush,
    input  lc3b_pipe_pkg::ctrl_t    i_ctrl,
    input  lc3b_pipe_pkg::reg_idx_t i_dest,
    input  lc3b_pipe_pkg::reg_idx_t i_src1,
    input  lc3b_pipe_pkg::reg_idx_t i_src2,
    input  lc3b_pipe_pkg::word_t    i_rdata_a,
    input  lc3b_pipe_pkg::word_t    i_rdata_b,
    input  lc3b_pipe_pkg::word_t    i_imm,
    input  lc3b_pipe_pkg::word_t    i_pc,
    input  lc3b_pipe_pkg::word_t    i_fwd_mem,
    input  lc3b_pipe_pkg::word_t    i_fwd_wb,
    input  lc3b_pipe_pkg::reg_idx_t i_dest_mem,
    input  lc3b_pipe_pkg::reg_idx_t i_dest_wb,
    input  logic                    i_we_mem,
    input  logic                    i_we_wb,
    output lc3b_pipe_pkg::ex_mem_t  o_ex_mem
);

    lc3b_pipe_pkg::id_ex_t   id_ex_q;
    lc3b_pipe_pkg::fwd_sel_e sel_a;
    lc3b_pipe_pkg::fwd_sel_e sel_b;
    lc3b_pipe_pkg::word_t    op_a;
    lc3b_pipe_pkg::word_t    op_b;
    lc3b_pipe_pkg::word_t    alu_b;
    lc3b_pipe_pkg::word_t    alu_out;
    lc3b_pipe_pkg::word_t    imm5_sext;
    lc3b_pipe_pkg::word_t    off6_adj;
    lc3b_pipe_pkg::word_t    off9_adj;

    function automatic lc3b_pipe_pkg::word_t fwd_pick(input lc3b_pipe_pkg::fwd_sel_e sel,
                                                      input lc3b_pipe_pkg::word_t rf,
                                                      input lc3b_pipe_pkg::word_t mem_val,
                                                      input lc3b_pipe_pkg::word_t wb_val);
        case (sel)
            lc3b_pipe_pkg::FWD_MEM: return mem_val;
            lc3b_pipe_pkg::FWD_WB:  return wb_val;
            default:                return rf;
        endcase
    endfunction

    // id/ex register
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            id_ex_q <= '0;
        end else if (i_flush) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= '{i_ctrl, i_dest, i_src1, i_src2, i_rdata_a, i_rdata_b, i_pc, i_imm};
        end
    end

    lc3b_pipe_forward u_forward (
        .i_src1     (id_ex_q.src1),
        .i_src2     (id_ex_q.src2),
        .i_dest_mem (i_dest_mem),
        .i_dest_wb  (i_dest_wb),
        .i_we_mem   (i_we_mem),
        .i_we_wb    (i_we_wb),
        .o_sel_a    (sel_a),
        .o_sel_b    (sel_b)
    );

    assign op_a = fwd_pick(sel_a, id_ex_q.src1_data, i_fwd_mem, i_fwd_wb);
    assign op_b = fwd_pick(sel_b, id_ex_q.src2_data, i_fwd_mem, i_fwd_wb);

    // word offsets are scaled to byte addresses
    assign imm5_sext = {{11{id_ex_q.imm[4]}}, id_ex_q.imm[4:0]};
    assign off6_adj  = {{9{id_ex_q.imm[5]}}, id_ex_q.imm[5:0], 1'b0};
    assign off9_adj  = {{6{id_ex_q.imm[8]}}, id_ex_q.imm[8:0], 1'b0};

    always_comb begin
        case (id_ex_q.ctrl.alu_b_sel)
            lc3b_pipe_pkg::B_IMM5: alu_b = imm5_sext;
            lc3b_pipe_pkg::B_OFF6: alu_b = off6_adj;
            default:               alu_b = op_b;
        endcase

        case (id_ex_q.ctrl.alu_op)
            lc3b_pipe_pkg::ALU_AND: alu_out = op_a & alu_b;
            lc3b_pipe_pkg::ALU_NOT: alu_out = ~op_a;
            lc3b_pipe_pkg::ALU_PASS_B: alu_out = alu_b;
            default:                alu_out = op_a + alu_b;
        endcase
    end

    assign o_ex_mem.ctrl        = id_ex_q.ctrl;
    assign o_ex_mem.dest        = id_ex_q.dest;
    assign o_ex_mem.alu         = alu_out;
    assign o_ex_mem.pc_plus_off = id_ex_q.pc + off9_adj;
    assign o_ex_mem.wdata       = op_b;
    assign o_ex_mem.nzp         = id_ex_q.dest;

endmodule

//--- lc3b_pipe_memwb.sv
`timescale 1ns/10ps

module lc3b_pipe_memwb (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  lc3b_pipe_pkg::ex_mem_t  i_ex_mem,
    input  lc3b_pipe_pkg::word_t    i_d_mem_rdata,
    output lc3b_pipe_pkg::word_t    o_d_mem_address,
    output lc3b_pipe_pkg::word_t    o_d_mem_wdata,
    output logic                    o_d_mem_read,
    output logic                    o_d_mem_write,
    output lc3b_pipe_pkg::word_t    o_fwd_mem,
    output lc3b_pipe_pkg::word_t    o_fwd_wb,
    output lc3b_pipe_pkg::reg_idx_t o_dest_mem,
    output lc3b_pipe_pkg::reg_idx_t o_dest_wb,
    output logic                    o_we_mem,
    output logic                    o_we_wb,
    output logic                    o_flush,
    output lc3b_pipe_pkg::word_t    o_target
);

    lc3b_pipe_pkg::ex_mem_t ex_mem_q;
    lc3b_pipe_pkg::mem_wb_t mem_wb_q;
    lc3b_pipe_pkg::word_t   wb_data;
    lc3b_pipe_pkg::nzp_t    cc_q;
    lc3b_pipe_pkg::nzp_t    gencc;

    // a redirect in wb kills everything younger, including the mem stage
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ex_mem_q <= '0;
            mem_wb_q <= '0;
        end else if (o_flush) begin
            ex_mem_q <= '0;
            mem_wb_q <= '0;
        end else begin
            ex_mem_q <= i_ex_mem;
            mem_wb_q <= '{ex_mem_q.ctrl, ex_mem_q.dest, ex_mem_q.alu, i_d_mem_rdata,
                          ex_mem_q.pc_plus_off, ex_mem_q.nzp};
        end
    end

    assign o_d_mem_address = ex_mem_q.alu;
    assign o_d_mem_wdata   = ex_mem_q.wdata;
    assign o_d_mem_read    = ex_mem_q.ctrl.mem_read & ~o_flush;
    assign o_d_mem_write   = ex_mem_q.ctrl.mem_write & ~o_flush;

    // load data is not ready for forwarding until wb
    assign o_fwd_mem  = (ex_mem_q.ctrl.wb_sel == lc3b_pipe_pkg::WB_PC_OFF) ?
                        ex_mem_q.pc_plus_off : ex_mem_q.alu;
    assign o_dest_mem = ex_mem_q.dest;
    assign o_we_mem   = ex_mem_q.ctrl.load_regfile;

    always_comb begin
        case (mem_wb_q.ctrl.wb_sel)
            lc3b_pipe_pkg::WB_MEM:    wb_data = mem_wb_q.rdata;
            lc3b_pipe_pkg::WB_PC_OFF: wb_data = mem_wb_q.pc_plus_off;
            default:                  wb_data = mem_wb_q.alu;
        endcase
    end

    assign o_fwd_wb  = wb_data;
    assign o_dest_wb = mem_wb_q.dest;
    assign o_we_wb   = mem_wb_q.ctrl.load_regfile;

    // n z p from the value being written
    assign gencc = wb_data[15] ? 3'b100 : ((wb_data == '0) ? 3'b010 : 3'b001);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cc_q <= '0;
        end else if (mem_wb_q.ctrl.load_cc) begin
            cc_q <= gencc;
        end
    end

    // branch resolution against the cc left by older instructions
    assign o_flush  = mem_wb_q.ctrl.is_jump |
                      (mem_wb_q.ctrl.is_branch & |(mem_wb_q.nzp & cc_q));
    assign o_target = mem_wb_q.ctrl.is_jump ? mem_wb_q.alu : mem_wb_q.pc_plus_off;

endmodule

//--- lc3b_pipe_top.sv
`timescale 1ns/10ps

module lc3b_pipe_top (
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  lc3b_pipe_pkg::word_t i_i_mem_rdata,
    output lc3b_pipe_pkg::word_t o_i_mem_address,
    output lc3b_pipe_pkg::word_t o_d_mem_address,
    output lc3b_pipe_pkg::word_t o_d_mem_wdata,
    output logic                 o_d_mem_read,
    output logic                 o_d_mem_write,
    input  lc3b_pipe_pkg::word_t i_d_mem_rdata
);

    lc3b_pipe_pkg::word_t    ifid_instr;
    lc3b_pipe_pkg::word_t    ifid_pc;
    lc3b_pipe_pkg::ctrl_t    ctrl;
    lc3b_pipe_pkg::reg_idx_t dest;
    lc3b_pipe_pkg::reg_idx_t src1;
    lc3b_pipe_pkg::reg_idx_t src2;
    lc3b_pipe_pkg::word_t    imm;
    lc3b_pipe_pkg::word_t    rdata_a;
    lc3b_pipe_pkg::word_t    rdata_b;
    lc3b_pipe_pkg::ex_mem_t  ex_mem;
    lc3b_pipe_pkg::word_t    fwd_mem;
    lc3b_pipe_pkg::word_t    fwd_wb;
    lc3b_pipe_pkg::reg_idx_t dest_mem;
    lc3b_pipe_pkg::reg_idx_t dest_wb;
    logic                    we_mem;
    logic                    we_wb;
    logic                    flush;
    lc3b_pipe_pkg::word_t    target;

    lc3b_pipe_fetch u_fetch (
        .clk, .i_arst_n,
        .i_instr      (i_i_mem_rdata),
        .i_flush      (flush),
        .i_target     (target),
        .o_pc         (o_i_mem_address),
        .o_ifid_instr (ifid_instr),
        .o_ifid_pc    (ifid_pc)
    );

    lc3b_pipe_decode u_decode (
        .i_instr (ifid_instr),
        .o_ctrl  (ctrl),
        .o_dest  (dest),
        .o_src1  (src1),
        .o_src2  (src2),
        .o_imm   (imm)
    );

    // wb drives the write port with its forward value
    lc3b_pipe_regfile u_regfile (
        .clk, .i_arst_n,
        .i_we      (we_wb),
        .i_waddr   (dest_wb),
        .i_wdata   (fwd_wb),
        .i_raddr_a (src1),
        .i_raddr_b (src2),
        .o_rdata_a (rdata_a),
        .o_rdata_b (rdata_b)
    );

    lc3b_pipe_execute u_execute (
        .clk, .i_arst_n,
        .i_flush    (flush),
        .i_ctrl     (ctrl),
        .i_dest     (dest),
        .i_src1     (src1),
        .i_src2     (src2),
        .i_rdata_a  (rdata_a),
        .i_rdata_b  (rdata_b),
        .i_imm      (imm),
        .i_pc       (ifid_pc),
        .i_fwd_mem  (fwd_mem),
        .i_fwd_wb   (fwd_wb),
        .i_dest_mem (dest_mem),
        .i_dest_wb  (dest_wb),
        .i_we_mem   (we_mem),
        .i_we_wb    (we_wb),
        .o_ex_mem   (ex_mem)
    );

    lc3b_pipe_memwb u_memwb (
        .clk, .i_arst_n,
        .i_ex_mem        (ex_mem),
        .i_d_mem_rdata   (i_d_mem_rdata),
        .o_d_mem_address (o_d_mem_address),
        .o_d_mem_wdata   (o_d_mem_wdata),
        .o_d_mem_read    (o_d_mem_read),
        .o_d_mem_write   (o_d_mem_write),
        .o_fwd_mem       (fwd_mem),
        .o_fwd_wb        (fwd_wb),
        .o_dest_mem      (dest_mem),
        .o_dest_wb       (dest_wb),
        .o_we_mem        (we_mem),
        .o_we_wb         (we_wb),
        .o_flush         (flush),
        .o_target        (target)
    );

endmodule

//--- lc3b_pipe_tb.sv
`timescale 1ns/10ps

module lc3b_pipe_tb;

    localparam int NUM_TESTS       = 5;
    localparam int PROG_TOTAL      = 79;
    localparam int INIT_TOTAL      = 2;
    localparam int EXP_TOTAL       = 16;
    localparam int ROM_WORDS       = 64;
    localparam int RAM_WORDS       = 256;
    localparam int CLK_HALF        = 10;
    localparam int DRIVE_DELAY     = 1;
    localparam int RESET_CYCLES    = 16;
    localparam int DRAIN_CYCLES    = 16;
    localparam int CYCLES_PER_WORD = 64;
    localparam logic [31:0] SEED   = 32'hb4efef48;

    typedef struct packed {
        lc3b_pipe_pkg::word_t addr;
        lc3b_pipe_pkg::word_t data;
    } mem_pair_t;

    // slices into the flat tables below
    typedef struct packed {
        logic [7:0] prog_start;
        logic [7:0] prog_len;
        logic [7:0] init_start;
        logic [7:0] init_cnt;
        logic [7:0] exp_start;
        logic [7:0] exp_cnt;
        // ldr instructions that reach mem
        logic [7:0] load_cnt;
    } test_t;

    localparam test_t TESTS [NUM_TESTS] = '{
        {8'd0,  8'd12, 8'd0, 8'd0, 8'd0,  8'd4, 8'd0},
        {8'd12, 8'd14, 8'd0, 8'd2, 8'd4,  8'd3, 8'd3},
        {8'd26, 8'd7,  8'd2, 8'd0, 8'd7,  8'd3, 8'd0},
        {8'd33, 8'd24, 8'd2, 8'd0, 8'd10, 8'd4, 8'd0},
        {8'd57, 8'd22, 8'd2, 8'd0, 8'd14, 8'd2, 8'd0}
    };

    localparam lc3b_pipe_pkg::word_t PROG_WORDS [PROG_TOTAL] = '{
        // alu chains through mem and wb forwarding
        16'h1225, 16'h1463, 16'h1642, 16'h58E7, 16'h9B3F, 16'h5D43, 16'h7C10, 16'h7A11,
        16'h7612, 16'h1F7F, 16'h7E82, 16'h0FFF,
        // ldr then use two slots later
        16'h122F, 16'h1241, 16'h1262, 16'h1241, 16'h6440, 16'h6643, 16'h18A7, 16'h1AF0,
        16'h7844, 16'h7A7E, 16'h6C44, 16'h1E20, 16'h7C45, 16'h0FFF,
        // lea
        16'hE210, 16'hE5FD, 16'h7214, 16'h7415, 16'hE600, 16'h76C1, 16'h0FFF,
        // brn, brz, brp taken, then brnz not taken
        16'h123F, 16'h0804, 16'h7201, 16'h7202, 16'h7203, 16'h7204, 16'h54A0, 16'h0404,
        16'h7205, 16'h7206, 16'h7207, 16'h7208, 16'h1629, 16'h0204, 16'h7209, 16'h720A,
        16'h720B, 16'h720C, 16'h0C04, 16'h7610, 16'h7211, 16'h7412, 16'h7613, 16'h0FFF,
        // jmp to computed targets
        16'hE207, 16'h1264, 16'hC040, 16'h7201, 16'h7202, 16'h7203, 16'h7204, 16'h7205,
        16'h7206, 16'h7207, 16'h7210, 16'h1441, 16'hC080, 16'h7401, 16'h7402, 16'h7403,
        16'h7404, 16'h7405, 16'h7406, 16'h7407, 16'h7411, 16'h0FFF
    };

    localparam mem_pair_t INIT_DATA [INIT_TOTAL] = '{
        {16'h0040, 16'h1234},
        {16'h0046, 16'h0F00}
    };

    // byte address and data of each store, in program order
    localparam mem_pair_t EXP_STORES [EXP_TOTAL] = '{
        {16'h0020, 16'h0008}, {16'h0022, 16'hFFFA}, {16'h0024, 16'h000D}, {16'h000C, 16'hFFF9},
        {16'h0048, 16'h123B}, {16'h003C, 16'h0EF0}, {16'h004A, 16'h123B},
        {16'h0028, 16'h0022}, {16'h002A, 16'hFFFE}, {16'h000C, 16'h000A},
        {16'h0020, 16'h0009}, {16'h0022, 16'hFFFF}, {16'h0024, 16'h0000}, {16'h0026, 16'h0009},
        {16'h0020, 16'h0014}, {16'h0022, 16'h0028}
    };

    logic                 clk = 1'b0;
    logic                 i_arst_n;
    lc3b_pipe_pkg::word_t i_mem_address;
    lc3b_pipe_pkg::word_t i_mem_rdata;
    lc3b_pipe_pkg::word_t d_mem_address;
    lc3b_pipe_pkg::word_t d_mem_wdata;
    lc3b_pipe_pkg::word_t d_mem_rdata;
    logic                 d_mem_read;
    logic                 d_mem_write;
    lc3b_pipe_pkg::word_t rom [ROM_WORDS];
    lc3b_pipe_pkg::word_t ram [RAM_WORDS];
    test_t                cur;
    int                   cur_test = 0;
    int                   checks_done = 0;
    int                   loads_seen = 0;
    logic                 checking = 1'b0;

    always #CLK_HALF clk = ~clk;

    lc3b_pipe_top i_dut (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_i_mem_rdata   (i_mem_rdata),
        .o_i_mem_address (i_mem_address),
        .o_d_mem_address (d_mem_address),
        .o_d_mem_wdata   (d_mem_wdata),
        .o_d_mem_read    (d_mem_read),
        .o_d_mem_write   (d_mem_write),
        .i_d_mem_rdata   (d_mem_rdata)
    );

    // both memories answer in the same cycle
    assign i_mem_rdata = rom[i_mem_address[6:1]];
    assign d_mem_rdata = ram[d_mem_address[8:1]];

    always @(posedge clk) begin
        if (d_mem_write) begin
            ram[d_mem_address[8:1]] <= d_mem_wdata;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic compare_word(input string name, input lc3b_pipe_pkg::word_t got,
                                input lc3b_pipe_pkg::word_t expected);
        if (got !== expected) begin
            abort_run($sformatf("MISMATCH %s got 0x%h expected 0x%h in test %0d",
                                name, got, expected, cur_test));
        end
    endtask

    task automatic load_memories(input test_t t);
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = lc3b_pipe_pkg::NOP_INSTR;
        end
        for (int i = 0; i < t.prog_len; i++) begin
            rom[i] = PROG_WORDS[t.prog_start + i];
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] = lc3b_pipe_pkg::word_t'($urandom);
        end
        for (int i = 0; i < t.init_cnt; i++) begin
            ram[INIT_DATA[t.init_start + i].addr[8:1]] = INIT_DATA[t.init_start + i].data;
        end
    endtask

    task automatic reset_and_load(input test_t t);
        @(posedge clk);
        #DRIVE_DELAY i_arst_n = 1'b0;
        load_memories(t);
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        // data strobes stay quiet while the pipeline is held in reset
        compare_word("o_d_mem_read", d_mem_read, 16'h0000);
        compare_word("o_d_mem_write", d_mem_write, 16'h0000);
        i_arst_n = 1'b1;
    endtask

    // every cycle with the write strobe high is one store
    always @(negedge clk) begin
        if (checking && d_mem_read) begin
            loads_seen++;
        end
        if (checking && d_mem_write) begin
            if (checks_done >= cur.exp_start + cur.exp_cnt) begin
                abort_run($sformatf("test %0d made an unexpected store to address 0x%h",
                                    cur_test, d_mem_address));
            end else begin
                compare_word("o_d_mem_address", d_mem_address, EXP_STORES[checks_done].addr);
                compare_word("o_d_mem_wdata", d_mem_wdata, EXP_STORES[checks_done].data);
                checks_done++;
            end
        end
    end

    initial begin : watchdog
        int budget;
        budget = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            budget += TESTS[t].prog_len * CYCLES_PER_WORD + RESET_CYCLES + DRAIN_CYCLES + 2;
        end
        #(budget * 2 * CLK_HALF);
        abort_run($sformatf("timeout, the program of test %0d did not finish", cur_test));
    end

    initial begin : run
        i_arst_n = 1'b0;
        cur      = TESTS[0];
        void'($urandom(SEED));
        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_test   = t;
            cur        = TESTS[t];
            checking   = 1'b0;
            loads_seen = 0;
            reset_and_load(cur);
            checking = 1'b1;
            wait (checks_done == cur.exp_start + cur.exp_cnt);
            // extra stores from the loop shadow would show up here
            repeat (DRAIN_CYCLES) @(posedge clk);
            compare_word("o_d_mem_read count", lc3b_pipe_pkg::word_t'(loads_seen),
                         cur.load_cnt);
            $display("test %0d done, %0d stores checked", t, cur.exp_cnt);
        end
        checking = 1'b0;
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- lc3b_pipe.f
lc3b_pipe_pkg.sv
lc3b_pipe_fetch.sv
lc3b_pipe_decode.sv
lc3b_pipe_regfile.sv
lc3b_pipe_forward.sv
lc3b_pipe_execute.sv
lc3b_pipe_memwb.sv
lc3b_pipe_top.sv
lc3b_pipe_tb.sv
